//--- axi_mem_tb.sv
/* testbench for the AXI memory checking one response per handshake in issue order
   random traffic stays in the lowest 16 words while random upper address bits hit the wrap */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module axi_mem_tb
  import bridge_pkg::*;
;

  localparam int wait_limit = 200;

  // one expected response in issue order
  typedef struct packed {
    logic                   is_write;
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
  } exp_s;

  logic clk_i, reset_i;
  axi_ax_s aw, ar;
  axi_w_s  w;
  logic awvalid, awready, wvalid, wready, arvalid, arready;
  logic bvalid, bready, rvalid, rready;
  logic [`AXI_ID_W-1:0]   bid, rid;
  logic [`AXI_DATA_W-1:0] rdata;

  logic [`AXI_DATA_W-1:0] shadow [1 << `MEM_WORDS_LOG2];
  exp_s   exp_q [$];
  integer seed = 32'h74eb_0388;
  integer stall_seed;
  int     errors = 0;
  int     passes = 0;
  logic   stall_en;
  logic   b_hold, r_hold;
  logic [`AXI_ID_W-1:0]   held_bid, held_rid;
  logic [`AXI_DATA_W-1:0] held_rdata;

  axi_mem_top i_axi_mem_top (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .s_axi_aw_i     (aw),
    .s_axi_awvalid_i(awvalid),
    .s_axi_awready_o(awready),
    .s_axi_w_i      (w),
    .s_axi_wvalid_i (wvalid),
    .s_axi_wready_o (wready),
    .s_axi_bid_o    (bid),
    .s_axi_bvalid_o (bvalid),
    .s_axi_bready_i (bready),
    .s_axi_ar_i     (ar),
    .s_axi_arvalid_i(arvalid),
    .s_axi_arready_o(arready),
    .s_axi_rid_o    (rid),
    .s_axi_rdata_o  (rdata),
    .s_axi_rvalid_o (rvalid),
    .s_axi_rready_i (rready)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // expected word after a strobed write
  function automatic logic [`AXI_DATA_W-1:0] ref_merge(input logic [`AXI_DATA_W-1:0] old,
      input logic [`AXI_DATA_W-1:0] data, input logic [`AXI_STRB_W-1:0] strb);
    logic [`AXI_DATA_W-1:0] res;
    res = old;
    for (int i = 0; i < `AXI_STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  task automatic finish_run();
    $display("checks passed %0d, errors %0d", passes, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic check_rdata(input string name, input logic [`AXI_DATA_W-1:0] got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end else begin
      passes++;
    end
  endtask

  task automatic check_id(input string name, input logic [`AXI_ID_W-1:0] got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end else begin
      passes++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end else begin
      passes++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
    end
  endtask

  task automatic expect_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [`AXI_ID_W-1:0] id,
      input logic [`AXI_DATA_W-1:0] data, input logic [`AXI_STRB_W-1:0] strb);
    logic [`MEM_WORDS_LOG2-1:0] idx;
    idx = addr[`MEM_WORDS_LOG2+2:3];
    shadow[idx] = ref_merge(shadow[idx], data, strb);
    exp_q.push_back('{is_write: 1'b1, id: id, data: '0});
  endtask

  task automatic expect_read(input logic [`AXI_ADDR_W-1:0] addr, input logic [`AXI_ID_W-1:0] id);
    logic [`MEM_WORDS_LOG2-1:0] idx;
    idx = addr[`MEM_WORDS_LOG2+2:3];
    exp_q.push_back('{is_write: 1'b0, id: id, data: shadow[idx]});
  endtask

  // drives AW and W together and returns after both handshakes
  task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [`AXI_ID_W-1:0] id,
      input logic [`AXI_DATA_W-1:0] data, input logic [`AXI_STRB_W-1:0] strb);
    logic aw_done, w_done;
    int   cnt;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cnt     = 0;
    @(posedge clk_i);
    aw      <= '{addr: addr, id: id};
    awvalid <= 1'b1;
    w       <= '{data: data, strb: strb};
    wvalid  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(posedge clk_i);
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end
      cnt++;
      if (cnt > wait_limit) begin
        $display("timeout: write address or data was never accepted at %0t", $time);
        errors++;
        finish_run();
      end
    end
  endtask

  task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr, input logic [`AXI_ID_W-1:0] id);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    ar      <= '{addr: addr, id: id};
    arvalid <= 1'b1;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > wait_limit) begin
        $display("timeout: read address was never accepted at %0t", $time);
        errors++;
        finish_run();
      end
    end while (!(arvalid && arready));
    arvalid <= 1'b0;
  endtask

  // waits until every expected response has been seen
  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      cnt++;
      if (cnt > wait_limit) begin
        $display("timeout: %0d responses never arrived at %0t", exp_q.size(), $time);
        errors++;
        finish_run();
      end
    end
  endtask

  // random ready stalls
  always @(posedge clk_i) begin
    logic [31:0] r;
    if (stall_en) begin
      r = $random(stall_seed);
      bready <= (r[1:0] != 2'b00);
      rready <= (r[3:2] != 2'b00);
    end
  end

  // compares responses in issue order and checks them stable while stalled
  always @(posedge clk_i) begin
    exp_s e;
    if (!reset_i) begin
      if (b_hold) begin
        check_bit("bvalid", bvalid, 1'b1);
        check_id("bid", bid, held_bid);
      end
      if (r_hold) begin
        check_bit("rvalid", rvalid, 1'b1);
        check_id("rid", rid, held_rid);
        check_rdata("rdata", rdata, held_rdata);
      end
      if ((bvalid && bready) || (rvalid && rready)) begin
        if (exp_q.size() == 0) begin
          $display("unexpected response with nothing outstanding at %0t", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          if (bvalid) begin
            check_bit("bvalid", bvalid, e.is_write);
            check_id("bid", bid, e.id);
          end else begin
            check_bit("rvalid", rvalid, ~e.is_write);
            check_id("rid", rid, e.id);
            check_rdata("rdata", rdata, e.data);
          end
        end
      end
    end
    b_hold     <= bvalid && !bready;
    r_hold     <= rvalid && !rready;
    held_bid   <= bid;
    held_rid   <= rid;
    held_rdata <= rdata;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    int          err0;
    int          n;
    aw       = '0;
    w        = '0;
    ar       = '0;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    arvalid  = 1'b0;
    bready   = 1'b1;
    rready   = 1'b1;
    stall_en = 1'b0;
    b_hold   = 1'b0;
    r_hold   = 1'b0;
    reset_i  = 1'b1;
    stall_seed = $random(seed);
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    err0 = errors;
    check_bit("bvalid", bvalid, 1'b0);
    check_bit("rvalid", rvalid, 1'b0);
    check_bit("awready", awready, 1'b1);
    check_bit("wready", wready, 1'b1);
    check_bit("arready", arready, 1'b1);
    report_test(1, "reset state", err0);

    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      a = 32'(i) << 3;
      expect_write(a, 4'(i + 1), {16'h5a5a, 16'(i), 32'hc0de_0000 + 32'(i)}, 8'hff);
      axi_write(a, 4'(i + 1), {16'h5a5a, 16'(i), 32'hc0de_0000 + 32'(i)}, 8'hff);
      wait_idle();
    end
    for (int i = 0; i < 4; i++) begin
      a = 32'(i) << 3;
      expect_read(a, 4'(i + 8));
      axi_read(a, 4'(i + 8));
      wait_idle();
    end
    report_test(2, "write then read", err0);

    err0 = errors;
    a = 32'h0000_0040;
    expect_write(a, 4'h3, 64'h0123_4567_89ab_cdef, 8'hff);
    axi_write(a, 4'h3, 64'h0123_4567_89ab_cdef, 8'hff);
    wait_idle();
    expect_write(a, 4'h4, 64'hffee_ddcc_bbaa_9988, 8'b1010_0101);
    axi_write(a, 4'h4, 64'hffee_ddcc_bbaa_9988, 8'b1010_0101);
    wait_idle();
    expect_write(a, 4'h5, 64'h1122_3344_5566_7788, 8'b0000_0110);
    axi_write(a, 4'h5, 64'h1122_3344_5566_7788, 8'b0000_0110);
    wait_idle();
    expect_read(a, 4'h6);
    axi_read(a, 4'h6);
    wait_idle();
    report_test(3, "byte strobes", err0);

    err0 = errors;
    // read is queued first and must see the old word
    expect_read(32'h0000_0008, 4'ha);
    expect_write(32'h0000_0008, 4'hb, 64'hdead_beef_0bad_f00d, 8'hff);
    fork
      axi_read(32'h0000_0008, 4'ha);
      axi_write(32'h0000_0008, 4'hb, 64'hdead_beef_0bad_f00d, 8'hff);
    join
    wait_idle();
    expect_read(32'h0000_0008, 4'hc);
    axi_read(32'h0000_0008, 4'hc);
    wait_idle();
    report_test(4, "read priority", err0);

    err0 = errors;
    @(posedge clk_i);
    bready <= 1'b0;
    expect_write(32'h0000_0010, 4'h7, 64'h7777_6666_5555_4444, 8'hff);
    axi_write(32'h0000_0010, 4'h7, 64'h7777_6666_5555_4444, 8'hff);
    expect_read(32'h0000_0010, 4'h2);
    axi_read(32'h0000_0010, 4'h2);
    r = $random(seed);
    n = 4 + int'(r[3:0]);
    repeat (n) begin
      @(posedge clk_i);
      check_bit("awready", awready, 1'b0);
      check_bit("arready", arready, 1'b0);
      check_bit("rvalid", rvalid, 1'b0);
    end
    bready <= 1'b1;
    wait_idle();
    @(posedge clk_i);
    rready <= 1'b0;
    expect_read(32'h0000_0018, 4'h9);
    axi_read(32'h0000_0018, 4'h9);
    r = $random(seed);
    n = 4 + int'(r[3:0]);
    repeat (n) begin
      @(posedge clk_i);
      check_bit("arready", arready, 1'b0);
      check_bit("bvalid", bvalid, 1'b0);
    end
    rready <= 1'b1;
    wait_idle();
    report_test(5, "back-pressure", err0);

    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      a = 32'(i) << 3;
      expect_write(a, 4'h0, {$random(seed), $random(seed)}, 8'hff);
      axi_write(a, 4'h0, shadow[i], 8'hff);
      wait_idle();
    end
    @(posedge clk_i);
    stall_en <= 1'b1;
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      a = {r[31:11], 4'b0000, r[3:0], 3'b000};
      if (r[4]) begin
        logic [`AXI_DATA_W-1:0] d;
        d = {$random(seed), $random(seed)};
        expect_write(a, r[8:5], d, r[10:9] == 2'b00 ? 8'hff : d[7:0]);
        axi_write(a, r[8:5], d, r[10:9] == 2'b00 ? 8'hff : d[7:0]);
      end else begin
        expect_read(a, r[8:5]);
        axi_read(a, r[8:5]);
      end
      wait_idle();
    end
    @(posedge clk_i);
    stall_en <= 1'b0;
    @(posedge clk_i);
    bready <= 1'b1;
    rready <= 1'b1;
    report_test(6, "random traffic", err0);

    finish_run();
  end

endmodule

`default_nettype wire

//--- axi_mem_top.sv
/* AXI4 subordinate memory, single-beat 64-bit transfers only
   every response is OKAY and last */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module axi_mem_top
  import bridge_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  axi_ax_s                s_axi_aw_i,
  input  logic                   s_axi_awvalid_i,
  output logic                   s_axi_awready_o,

  input  axi_w_s                 s_axi_w_i,
  input  logic                   s_axi_wvalid_i,
  output logic                   s_axi_wready_o,

  output logic [`AXI_ID_W-1:0]   s_axi_bid_o,
  output logic                   s_axi_bvalid_o,
  input  logic                   s_axi_bready_i,

  input  axi_ax_s                s_axi_ar_i,
  input  logic                   s_axi_arvalid_i,
  output logic                   s_axi_arready_o,

  output logic [`AXI_ID_W-1:0]   s_axi_rid_o,
  output logic [`AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic                   s_axi_rvalid_o,
  input  logic                   s_axi_rready_i
);

  // request and reply streams between bridge and memory
  mem_req_s  mem_req;
  logic      mem_req_v, mem_req_ready;
  mem_resp_s mem_resp;
  logic      mem_resp_v, mem_resp_ready;

  axi_to_fifo u_bridge (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .s_axi_aw_i      (s_axi_aw_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_w_i       (s_axi_w_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bid_o     (s_axi_bid_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_ar_i      (s_axi_ar_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rid_o     (s_axi_rid_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .mem_req_o       (mem_req),
    .mem_req_v_o     (mem_req_v),
    .mem_req_ready_i (mem_req_ready),
    .mem_resp_i      (mem_resp),
    .mem_resp_v_i    (mem_resp_v),
    .mem_resp_ready_o(mem_resp_ready)
  );

  fifo_mem u_mem (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (mem_req),
    .req_v_i     (mem_req_v),
    .req_ready_o (mem_req_ready),
    .resp_o      (mem_resp),
    .resp_v_o    (mem_resp_v),
    .resp_ready_i(mem_resp_ready)
  );

endmodule

`default_nettype wire

//--- axi_to_fifo.sv
/* AXI4 subordinate to in-order request stream, single beat, 64-bit data
   one request in flight, reads win over writes, responses are OKAY and last */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module axi_to_fifo
  import bridge_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  axi_ax_s                s_axi_aw_i,
  input  logic                   s_axi_awvalid_i,
  output logic                   s_axi_awready_o,

  input  axi_w_s                 s_axi_w_i,
  input  logic                   s_axi_wvalid_i,
  output logic                   s_axi_wready_o,

  output logic [`AXI_ID_W-1:0]   s_axi_bid_o,
  output logic                   s_axi_bvalid_o,
  input  logic                   s_axi_bready_i,

  input  axi_ax_s                s_axi_ar_i,
  input  logic                   s_axi_arvalid_i,
  output logic                   s_axi_arready_o,

  output logic [`AXI_ID_W-1:0]   s_axi_rid_o,
  output logic [`AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic                   s_axi_rvalid_o,
  input  logic                   s_axi_rready_i,

  output mem_req_s               mem_req_o,
  output logic                   mem_req_v_o,
  input  logic                   mem_req_ready_i,

  input  mem_resp_s              mem_resp_i,
  input  logic                   mem_resp_v_i,
  output logic                   mem_resp_ready_o
);

  axi_ax_s   aw_q, ar_q;
  axi_w_s    w_q;
  mem_resp_s resp_q;
  logic      aw_v, w_v, ar_v, resp_v;
  logic      b_fire, r_fire, req_fire;
  logic      pending_r;

  // AXI channel skid slots
  one_slot_fifo #(.width_p($bits(axi_ax_s))) aw_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (s_axi_aw_i),
    .v_i    (s_axi_awvalid_i),
    .ready_o(s_axi_awready_o),
    .data_o (aw_q),
    .v_o    (aw_v),
    .yumi_i (b_fire)
  );

  one_slot_fifo #(.width_p($bits(axi_w_s))) w_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (s_axi_w_i),
    .v_i    (s_axi_wvalid_i),
    .ready_o(s_axi_wready_o),
    .data_o (w_q),
    .v_o    (w_v),
    .yumi_i (b_fire)
  );

  one_slot_fifo #(.width_p($bits(axi_ax_s))) ar_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (s_axi_ar_i),
    .v_i    (s_axi_arvalid_i),
    .ready_o(s_axi_arready_o),
    .data_o (ar_q),
    .v_o    (ar_v),
    .yumi_i (r_fire)
  );

  // memory reply waits here until B or R takes it
  one_slot_fifo #(.width_p($bits(mem_resp_s))) resp_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (mem_resp_i),
    .v_i    (mem_resp_v_i),
    .ready_o(mem_resp_ready_o),
    .data_o (resp_q),
    .v_o    (resp_v),
    .yumi_i (b_fire | r_fire)
  );

  // issue only when idle and the reply slot is free
  assign mem_req_v_o = ~pending_r & mem_resp_ready_o & (ar_v | (aw_v & w_v));
  assign req_fire    = mem_req_v_o & mem_req_ready_i;

  always_comb begin
    mem_req_o.op    = ar_v ? e_mem_read : e_mem_write;
    mem_req_o.addr  = ar_v ? ar_q.addr : aw_q.addr;
    mem_req_o.data  = w_q.data;
    mem_req_o.wmask = w_q.strb;
  end

  // held from issue until the response is handed back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= 1'b0;
    end else if (req_fire) begin
      pending_r <= 1'b1;
    end else if (b_fire | r_fire) begin
      pending_r <= 1'b0;
    end
  end

  // reply op steers to B or R, ids come from the held slots
  assign s_axi_bvalid_o = resp_v & (resp_q.op == e_mem_write);
  assign s_axi_bid_o    = aw_q.id;
  assign b_fire         = s_axi_bvalid_o & s_axi_bready_i;

  assign s_axi_rvalid_o = resp_v & (resp_q.op == e_mem_read);
  assign s_axi_rid_o    = ar_q.id;
  assign s_axi_rdata_o  = resp_q.data;
  assign r_fire         = s_axi_rvalid_o & s_axi_rready_i;

endmodule

`default_nettype wire

//--- bridge_config.svh
/* widths and memory sizing for the AXI memory bridge
   data width must stay 64, memory latency must be 1 or more */
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// AXI bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_STRB_W (`AXI_DATA_W/8)
`define AXI_ID_W 4

// memory depth in 64-bit words, as log2
`define MEM_WORDS_LOG2 8

// cycles from request accept to reply offer
`define MEM_LATENCY 3

`endif

//--- bridge_pkg.sv
/* shared types for the AXI bridge and its memory
   single-beat, 64-bit only, all responses are OKAY */
`default_nettype none

`include "bridge_config.svh"

package bridge_pkg;

  // AW and AR share one item layout
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_ID_W-1:0]   id;
  } axi_ax_s;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axi_w_s;

  typedef enum logic {
    e_mem_read  = 1'b0,
    e_mem_write = 1'b1
  } mem_op_e;

  // request toward the memory client
  typedef struct packed {
    mem_op_e                op;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] wmask;
  } mem_req_s;

  // reply from the memory, always a whole word
  typedef struct packed {
    mem_op_e                op;
    logic [`AXI_DATA_W-1:0] data;
  } mem_resp_s;

  typedef enum logic [1:0] {
    e_mem_idle  = 2'd0,
    e_mem_wait  = 2'd1,
    e_mem_reply = 2'd2
  } mem_state_e;

endpackage

`default_nettype wire

//--- fifo_mem.sv
/* word memory answering one request at a time after MEM_LATENCY cycles
   upper address bits wrap, contents come up undefined */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module fifo_mem
  import bridge_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  mem_req_s  req_i,
  input  logic      req_v_i,
  output logic      req_ready_o,

  output mem_resp_s resp_o,
  output logic      resp_v_o,
  input  logic      resp_ready_i
);

  localparam int words_lp = 1 << `MEM_WORDS_LOG2;
  localparam int cnt_w_lp = $clog2(`MEM_LATENCY + 1);

  logic [`AXI_DATA_W-1:0]    mem_r [words_lp];
  logic [`MEM_WORDS_LOG2-1:0] idx;
  logic                       accept;

  mem_state_e           state_r;
  logic [cnt_w_lp-1:0]  cnt_r;
  mem_op_e              op_r;
  logic [`AXI_DATA_W-1:0] data_r;

  // word index sits above the byte offset
  assign idx    = req_i.addr[`MEM_WORDS_LOG2+2:3];
  assign accept = req_v_i & req_ready_o;

  assign req_ready_o = (state_r == e_mem_idle);
  assign resp_v_o    = (state_r == e_mem_reply);

  // byte lane merge on the accept edge
  always_ff @(posedge clk_i) begin
    if (accept && req_i.op == e_mem_write) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (req_i.wmask[i]) begin
          mem_r[idx][8*i +: 8] <= req_i.data[8*i +: 8];
        end
      end
    end
  end

  // reply payload, read word captured before any merge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r   <= req_i.op;
      data_r <= mem_r[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_mem_idle;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        e_mem_idle: begin
          if (accept) begin
            state_r <= e_mem_wait;
            cnt_r   <= cnt_w_lp'(`MEM_LATENCY - 1);
          end
        end
        e_mem_wait: begin
          if (cnt_r == '0) begin
            state_r <= e_mem_reply;
          end else begin
            cnt_r <= cnt_r - 1'b1;
          end
        end
        e_mem_reply: begin
          // hold until the client takes it
          if (resp_ready_i) begin
            state_r <= e_mem_idle;
          end
        end
        default: state_r <= e_mem_idle;
      endcase
    end
  end

  assign resp_o.op   = op_r;
  assign resp_o.data = data_r;

endmodule

`default_nettype wire

//--- one_slot_fifo.sv
/* one-entry queue, yumi_i may only rise while v_o is high */
`timescale 1ns/100ps
`default_nettype none

module one_slot_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic [width_p-1:0] data_i,
  input  logic               v_i,
  output logic               ready_o,

  output logic [width_p-1:0] data_o,
  output logic               v_o,
  input  logic               yumi_i
);

  logic               full_r;
  logic [width_p-1:0] data_r;
  logic               enq;

  // only enqueue into an empty slot
  assign enq = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (enq) begin
      full_r <= 1'b1;
    end else if (yumi_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      data_r <= data_i;
    end
  end

  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = data_r;

endmodule

`default_nettype wire

//--- project.f
+incdir+.
bridge_pkg.sv
one_slot_fifo.sv
axi_to_fifo.sv
fifo_mem.sv
axi_mem_top.sv
axi_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the AXI memory testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f project.f --top-module axi_mem_tb -o axi_mem_tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/axi_mem_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
